// File: tb.f
matrix_pkg.sv
max7219_pkg.sv
point_ctrl.sv
backg_scroller.sv
frame_composer.sv
row_fifo.sv
max7219_serial.sv
bb_system.sv
tb_bb_system.sv

// File: Bender.yml
package:
  name: bb_system

sources:
  - matrix_pkg.sv
  - max7219_pkg.sv
  - point_ctrl.sv
  - backg_scroller.sv
  - frame_composer.sv
  - row_fifo.sv
  - max7219_serial.sv
  - bb_system.sv
  - target: simulation
    files:
      - tb_bb_system.sv

// File: tb_bb_system.sv
//############################
// game testbench
// drives button pulses into the game top level, decodes the
// MAX7219 serial line into frames and checks them against
// a reference model of point, scrolling and crash
//############################
`timescale 1ns/1ps

module tb_bb_system;

	localparam int FRAMES_PER_MOVE = 4;
	localparam int FRAME_TIMEOUT   = 600;
	localparam int CRASH_TIMEOUT   = 20000;
	localparam int FREEZE_SKIP     = 3;
	localparam int NUM_PRESSES     = 16;

	logic                 clock_50;
	logic                 arst_n;
	matrix_pkg::buttons_t buttons;
	logic                 max7219_din;
	logic                 max7219_ncs;
	logic                 max7219_clk;
	logic                 crash;

	int err_word = 0;
	int err_row = 0;
	int err_bit = 0;
	int err_other = 0;
	// set by a wait that ran out of cycles
	bit timed_out = 1'b0;

	// serial decoder state
	logic [15:0] shift_in;
	int          bit_cnt = 0;
	logic [15:0] word_q [$];

	// frame tracking, written by the compare process
	int                     cfg_seen = 0;
	int                     row_n = 0;
	int                     frame_cnt = 0;
	int                     last_k = -1;
	int                     k_steps = 0;
	int                     crash_frames = 0;
	bit                     saw_overlap = 1'b0;
	matrix_pkg::frame_t     cur_frame;
	matrix_pkg::frame_t     last_frame;
	matrix_pkg::frame_t     frozen;
	matrix_pkg::point_pos_t pred;

	bb_system #(.SPEED_DIV(600), .FIFO_DEPTH(8)) bb_system_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.buttons     (buttons),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.crash       (crash)
	);

	initial begin
		clock_50 = 1'b0;
		forever #4 clock_50 = ~clock_50;
	end

	//############################
	// reference model
	//############################
	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// after k scroll steps row r shows initial row r+k
	function automatic matrix_pkg::frame_t rotated_backg(int k);
		matrix_pkg::frame_t f;
		for (int r = 0; r < 8; r++)
			f[r*8 +: 8] = matrix_pkg::BACKG_INIT[((r + k) % 8)*8 +: 8];
		return f;
	endfunction

	function automatic matrix_pkg::frame_t expected_frame(int k, matrix_pkg::point_pos_t p);
		matrix_pkg::frame_t f;
		f = rotated_backg(k);
		f[p.row*8 + p.col] = 1'b1;
		return f;
	endfunction

	// vertical first, then horizontal, saturating at 0 and 7
	function automatic matrix_pkg::point_pos_t move_point(matrix_pkg::point_pos_t p,
			matrix_pkg::buttons_t b);
		matrix_pkg::point_pos_t n;
		n = p;
		if (b.up && n.row < 3'd7)
			n.row = n.row + 3'd1;
		if (b.down && n.row > 3'd0)
			n.row = n.row - 3'd1;
		if (b.left && n.col < 3'd7)
			n.col = n.col + 3'd1;
		if (b.right && n.col > 3'd0)
			n.col = n.col - 3'd1;
		return n;
	endfunction

	// rotation that the frame holds, with at most one extra pixel, or -1
	function automatic int find_k(matrix_pkg::frame_t f);
		matrix_pkg::frame_t bg;
		int found;
		found = -1;
		for (int k = 0; k < 8; k++) begin
			bg = rotated_backg(k);
			if ((bg & ~f) == '0 && $countones(f & ~bg) <= 1)
				found = k;
		end
		return found;
	endfunction

	//############################
	// compare tasks and run control
	//############################
	task automatic check_word(string name, max7219_pkg::spi_word_t got,
			max7219_pkg::spi_word_t exp);
		if (got !== exp) begin
			err_word++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_row(string name, matrix_pkg::row_bits_t got,
			matrix_pkg::row_bits_t exp);
		if (got !== exp) begin
			err_row++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			err_bit++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic close_run();
		int total;
		total = err_word + err_row + err_bit + err_other;
		$display("errors: word %0d, row %0d, bit %0d, other %0d, total %0d",
			err_word, err_row, err_bit, err_other, total);
		if (total == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	task automatic report_timeout(string what);
		err_other++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic wait_frames(int n);
		int target;
		int cycles;
		target = frame_cnt + n;
		cycles = 0;
		while (frame_cnt < target && cycles < n * FRAME_TIMEOUT) begin
			@(negedge clock_50);
			cycles++;
		end
		if (frame_cnt < target)
			report_timeout($sformatf("%0d decoded frames", n));
	endtask

	task automatic wait_crash();
		int cycles;
		cycles = 0;
		while (!crash && cycles < CRASH_TIMEOUT) begin
			@(negedge clock_50);
			cycles++;
		end
		if (!crash)
			report_timeout("the crash flag");
	endtask

	// one-cycle pulse, ignored by a frozen game
	task automatic press(matrix_pkg::buttons_t b);
		@(negedge clock_50);
		buttons = b;
		if (!crash)
			pred = move_point(pred, b);
		@(negedge clock_50);
		buttons = '0;
	endtask

	task automatic check_point();
		matrix_pkg::frame_t exp;
		if (last_k >= 0) begin
			exp = expected_frame(last_k, pred);
			for (int r = 0; r < 8; r++)
				check_row($sformatf("point frame row %0d", r), last_frame[r*8 +: 8],
					exp[r*8 +: 8]);
		end
	endtask

	//############################
	// serial decoder
	//############################
	always @(posedge max7219_clk) begin
		if (max7219_ncs) begin
			err_other++;
			$display("serial clock rose while ncs was high");
		end
		shift_in = {shift_in[14:0], max7219_din};
		bit_cnt++;
	end

	// the reset edge of ncs carries no word
	always @(posedge max7219_ncs) begin
		if (arst_n) begin
			if (bit_cnt != 16) begin
				err_other++;
				$display("serial word ended after %0d bits", bit_cnt);
			end else begin
				word_q.push_back(shift_in);
			end
		end
		bit_cnt = 0;
	end

	task automatic finish_frame();
		matrix_pkg::frame_t exp;
		int k;
		k = find_k(cur_frame);
		if (k < 0) begin
			err_other++;
			$display("frame %0d is no rotated background with one point: %h",
				frame_cnt, cur_frame);
		end else begin
			if (frame_cnt == 0) begin
				exp = expected_frame(0, matrix_pkg::POINT_INIT);
				for (int r = 0; r < 8; r++)
					check_row($sformatf("first frame row %0d", r), cur_frame[r*8 +: 8],
						exp[r*8 +: 8]);
			end
			if (last_k >= 0 && k != last_k) begin
				if (k == (last_k + 1) % 8) begin
					k_steps++;
				end else begin
					err_other++;
					$display("background jumped from rotation %0d to %0d", last_k, k);
				end
			end
			// point hidden under a set background bit
			if (cur_frame == rotated_backg(k))
				saw_overlap = 1'b1;
		end
		last_k = k;
		last_frame = cur_frame;
		if (crash)
			crash_frames++;
		if (crash_frames == FREEZE_SKIP + 1) begin
			frozen = cur_frame;
			check_bit("frozen frame overlap", k >= 0 && frozen == rotated_backg(k), 1'b1);
		end else if (crash_frames > FREEZE_SKIP + 1) begin
			for (int r = 0; r < 8; r++)
				check_row($sformatf("frozen row %0d", r), cur_frame[r*8 +: 8],
					frozen[r*8 +: 8]);
		end
		frame_cnt++;
	endtask

	always @(posedge clock_50) begin : compare_words
		max7219_pkg::spi_word_t w;
		max7219_pkg::spi_word_t exp_w;
		while (word_q.size() > 0) begin
			w = word_q.pop_front();
			if (cfg_seen < 4) begin
				check_word($sformatf("config word %0d", cfg_seen), w,
					max7219_pkg::CONFIG_WORDS[cfg_seen]);
				cfg_seen++;
			end else begin
				// digit address is row plus one, data checked with the frame
				exp_w = '{rsvd: 4'h0, addr: max7219_pkg::reg_addr_t'(row_n + 1), data: w.data};
				check_word($sformatf("row %0d word", row_n), w, exp_w);
				cur_frame[row_n*8 +: 8] = w.data;
				if (row_n == 7) begin
					row_n = 0;
					finish_frame();
				end else begin
					row_n++;
				end
			end
		end
	end

	//############################
	// stimulus
	//############################
	// random moves, then a run to the left edge that ends in a crash
	task automatic run_game();
		logic [31:0]          seed;
		matrix_pkg::buttons_t b;
		seed = 32'hbdc77104;

		// let the background scroll before the point moves
		wait_frames(6);
		if (timed_out)
			return;

		for (int i = 0; i < NUM_PRESSES; i++) begin
			seed = lcg_next(seed);
			b = seed[27:24];
			if (b == '0)
				b.up = 1'b1;
			press(b);
			wait_frames(FRAMES_PER_MOVE);
			if (timed_out)
				return;
			if (!crash)
				check_point();
		end

		// run into the left edge, then into a background row
		b = '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
		for (int i = 0; i < 9; i++) begin
			press(b);
			wait_frames(FRAMES_PER_MOVE);
			if (timed_out)
				return;
			if (!crash)
				check_point();
		end
		wait_crash();
		if (timed_out)
			return;
		wait_frames(8);
		if (timed_out)
			return;

		check_bit("crash at end", crash, saw_overlap);
		if (k_steps == 0) begin
			err_other++;
			$display("background never scrolled during the run");
		end
	endtask

	initial begin : stimulus
		arst_n = 1'b0;
		buttons = '0;
		pred = matrix_pkg::POINT_INIT;
		repeat (3) @(negedge clock_50);
		arst_n = 1'b1;
		check_bit("max7219_ncs", max7219_ncs, 1'b1);
		check_bit("max7219_clk", max7219_clk, 1'b0);
		check_bit("crash", crash, 1'b0);
		run_game();
		close_run();
	end

endmodule

// File: bb_system.sv
//############################
// game top level
// point and background feed the frame composer, whose rows
// reach the MAX7219 serializer through a row FIFO
//############################
`timescale 1ns/1ps

module bb_system #(
	parameter int SPEED_DIV  = 12_500_000,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clock_50,
	input  logic                 arst_n,
	input  matrix_pkg::buttons_t buttons,
	output logic                 max7219_din,
	output logic                 max7219_ncs,
	output logic                 max7219_clk,
	output logic                 crash
);

	matrix_pkg::point_pos_t pos;
	matrix_pkg::frame_t     backg;
	logic                   halt;
	logic                   comp_valid;
	logic                   comp_ready;
	matrix_pkg::row_word_t  comp_word;
	logic                   ser_valid;
	logic                   ser_ready;
	matrix_pkg::row_word_t  ser_word;

	//############################
	// game state
	//############################
	point_ctrl point_ctrl_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.buttons  (buttons),
		.halt     (halt),
		.pos      (pos)
	);

	backg_scroller #(.SPEED_DIV(SPEED_DIV)) backg_scroller_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.halt     (halt),
		.backg    (backg)
	);

	frame_composer frame_composer_i (
		.clock_50  (clock_50),
		.arst_n    (arst_n),
		.pos       (pos),
		.backg     (backg),
		.out_valid (comp_valid),
		.out_ready (comp_ready),
		.out_word  (comp_word),
		.halt      (halt),
		.crash     (crash)
	);

	//############################
	// row stream to the matrix
	//############################
	row_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) row_fifo_i (
		.clock_50  (clock_50),
		.arst_n    (arst_n),
		.in_valid  (comp_valid),
		.in_ready  (comp_ready),
		.in_word   (comp_word),
		.out_valid (ser_valid),
		.out_ready (ser_ready),
		.out_word  (ser_word)
	);

	max7219_serial max7219_serial_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.in_valid    (ser_valid),
		.in_ready    (ser_ready),
		.in_word     (ser_word),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

// File: max7219_serial.sv
//############################
// MAX7219 serializer
// sends the start-up words, then one digit word per row word,
// MSB first with a half-rate serial clock, latched by ncs
//############################
`timescale 1ns/1ps

module max7219_serial (
	input  logic                  clock_50,
	input  logic                  arst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  matrix_pkg::row_word_t in_word,
	output logic                  max7219_din,
	output logic                  max7219_ncs,
	output logic                  max7219_clk
);

	max7219_pkg::serial_state_t state;
	max7219_pkg::spi_word_t     shreg;
	max7219_pkg::spi_word_t     row_spi;
	logic [2:0]                 cfg_cnt;
	logic [3:0]                 bit_cnt;
	logic                       cfg_done;

	assign cfg_done = cfg_cnt[2];
	assign in_ready = (state == max7219_pkg::ST_IDLE) && cfg_done;

	// digit registers 1..8 hold rows 0..7, column 7 goes out first
	assign row_spi = '{
		rsvd: 4'h0,
		addr: max7219_pkg::reg_addr_t'(in_word.row) + 4'd1,
		data: in_word.bits
	};

	//############################
	// word register
	//############################
	always_ff @(posedge clock_50) begin
		if (state == max7219_pkg::ST_IDLE) begin
			if (!cfg_done)
				shreg <= max7219_pkg::CONFIG_WORDS[cfg_cnt[1:0]];
			else if (in_valid)
				shreg <= row_spi;
		end else if (state == max7219_pkg::ST_SHIFT && max7219_clk) begin
			shreg <= shreg << 1;
		end
	end

	//############################
	// FSM and serial lines
	//############################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= max7219_pkg::ST_IDLE;
			cfg_cnt     <= '0;
			bit_cnt     <= '0;
			max7219_din <= 1'b0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			case (state)
				max7219_pkg::ST_IDLE: begin
					if (!cfg_done) begin
						cfg_cnt <= cfg_cnt + 3'd1;
						state   <= max7219_pkg::ST_LOAD;
					end else if (in_valid) begin
						state <= max7219_pkg::ST_LOAD;
					end
				end
				max7219_pkg::ST_LOAD: begin
					// select the chip with the first bit already on din
					max7219_ncs <= 1'b0;
					max7219_din <= shreg[15];
					bit_cnt     <= '0;
					state       <= max7219_pkg::ST_SHIFT;
				end
				max7219_pkg::ST_SHIFT: begin
					if (!max7219_clk) begin
						max7219_clk <= 1'b1;
					end else begin
						max7219_clk <= 1'b0;
						if (bit_cnt == 4'd15) begin
							state <= max7219_pkg::ST_LATCH;
						end else begin
							bit_cnt     <= bit_cnt + 4'd1;
							max7219_din <= shreg[14];
						end
					end
				end
				max7219_pkg::ST_LATCH: begin
					max7219_ncs <= 1'b1;
					max7219_din <= 1'b0;
					state       <= max7219_pkg::ST_IDLE;
				end
				default: state <= max7219_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

// File: row_fifo.sv
//############################
// row FIFO
// circular buffer of row words between composer and serializer
//############################
`timescale 1ns/1ps

module row_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                  clock_50,
	input  logic                  arst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  matrix_pkg::row_word_t in_word,
	output logic                  out_valid,
	input  logic                  out_ready,
	output matrix_pkg::row_word_t out_word
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	matrix_pkg::row_word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  push;
	logic                  pop;

	assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
	assign out_valid = (count != '0);
	assign out_word  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clock_50) begin
		if (push)
			mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leave the fill level unchanged
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: frame_composer.sv
//############################
// frame composer
// overlays point and background into frame snapshots, detects
// the crash and streams the rows out on valid/ready
//############################
`timescale 1ns/1ps

module frame_composer (
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  matrix_pkg::point_pos_t pos,
	input  matrix_pkg::frame_t     backg,
	output logic                   out_valid,
	input  logic                   out_ready,
	output matrix_pkg::row_word_t  out_word,
	output logic                   halt,
	output logic                   crash
);

	localparam int RW = $bits(matrix_pkg::row_bits_t);
	localparam matrix_pkg::row_idx_t LAST_ROW =
		matrix_pkg::row_idx_t'(matrix_pkg::MATRIX_SIZE - 1);

	logic                 init;
	logic                 xfer;
	logic                 take_snap;
	logic                 overlap;
	matrix_pkg::row_idx_t row_cnt;
	matrix_pkg::frame_t   point_mask;
	matrix_pkg::frame_t   live;
	// frame being sent, and the one taken for the next round
	matrix_pkg::frame_t   cur;
	matrix_pkg::frame_t   snap;

	always_comb begin
		point_mask = '0;
		point_mask[pos.row*RW + pos.col] = 1'b1;
	end

	assign live      = backg | point_mask;
	assign overlap   = |(backg & point_mask);
	assign xfer      = out_valid && out_ready;
	// a frozen game keeps its last snapshot
	assign take_snap = (init || (xfer && row_cnt == '0)) && !crash;

	assign out_word = '{row: row_cnt, bits: cur[row_cnt*RW +: RW]};
	assign halt     = crash;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			init      <= 1'b1;
			out_valid <= 1'b0;
			row_cnt   <= '0;
			crash     <= 1'b0;
		end else begin
			init <= 1'b0;
			if (init)
				out_valid <= 1'b1;
			// wraps from the top row back to row 0
			if (xfer)
				row_cnt <= row_cnt + 3'd1;
			if (take_snap && overlap)
				crash <= 1'b1;
		end
	end

	always_ff @(posedge clock_50) begin
		if (init)
			cur <= live;
		else if (xfer && row_cnt == LAST_ROW)
			cur <= snap;
		if (take_snap)
			snap <= live;
	end

endmodule

// File: backg_scroller.sv
//############################
// background scroller
// speed prescaler plus a rotating set of eight background
// rows, one step toward the bottom row per prescaler wrap
//############################
`timescale 1ns/1ps

module backg_scroller #(
	parameter int SPEED_DIV = 12_500_000
) (
	input  logic               clock_50,
	input  logic               arst_n,
	input  logic               halt,
	output matrix_pkg::frame_t backg
);

	localparam int CNT_W = (SPEED_DIV > 1) ? $clog2(SPEED_DIV) : 1;
	localparam int RW    = $bits(matrix_pkg::row_bits_t);

	logic [CNT_W-1:0]   div_cnt;
	logic               div_wrap;
	matrix_pkg::frame_t backg_rot;

	assign div_wrap = (div_cnt == CNT_W'(SPEED_DIV - 1));

	// row r takes row r+1, top row takes the old bottom row
	always_comb begin
		for (int r = 0; r < matrix_pkg::MATRIX_SIZE; r++) begin
			backg_rot[r*RW +: RW] = backg[((r + 1) % matrix_pkg::MATRIX_SIZE)*RW +: RW];
		end
	end

	//############################
	// prescaler and rows
	//############################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			backg   <= matrix_pkg::BACKG_INIT;
		end else if (!halt) begin
			if (div_wrap) begin
				div_cnt <= '0;
				backg   <= backg_rot;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// File: point_ctrl.sv
//############################
// point controller
// holds the player point and moves it one step per button
// pulse, saturating at the matrix edges
//############################
`timescale 1ns/1ps

module point_ctrl (
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  matrix_pkg::buttons_t   buttons,
	input  logic                   halt,
	output matrix_pkg::point_pos_t pos
);

	localparam matrix_pkg::row_idx_t EDGE_HI =
		matrix_pkg::row_idx_t'(matrix_pkg::MATRIX_SIZE - 1);

	matrix_pkg::point_pos_t pos_next;

	// vertical move first, then horizontal
	always_comb begin
		pos_next = pos;
		if (buttons.up && pos_next.row != EDGE_HI)
			pos_next.row = pos_next.row + 3'd1;
		if (buttons.down && pos_next.row != '0)
			pos_next.row = pos_next.row - 3'd1;
		if (buttons.left && pos_next.col != EDGE_HI)
			pos_next.col = pos_next.col + 3'd1;
		if (buttons.right && pos_next.col != '0)
			pos_next.col = pos_next.col - 3'd1;
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			pos <= matrix_pkg::POINT_INIT;
		end else if (!halt) begin
			pos <= pos_next;
		end
	end

endmodule

// File: max7219_pkg.sv
//############################
// max7219 package
// register map and word format of the MAX7219 serial protocol
//############################
package max7219_pkg;

	typedef logic [3:0] reg_addr_t;

	// sent MSB first, 16 bits per word
	typedef struct packed {
		logic [3:0] rsvd;
		reg_addr_t  addr;
		logic [7:0] data;
	} spi_word_t;

	localparam reg_addr_t REG_DECODE     = 4'h9;
	localparam reg_addr_t REG_INTENSITY  = 4'hA;
	localparam reg_addr_t REG_SCAN_LIMIT = 4'hB;
	localparam reg_addr_t REG_SHUTDOWN   = 4'hC;

	localparam logic [3:0] INTENSITY = 4'hA;

	// start-up sequence, index 0 goes out first
	localparam spi_word_t CONFIG_WORDS [0:3] = '{
		'{rsvd: 4'h0, addr: REG_DECODE,     data: 8'h00},
		'{rsvd: 4'h0, addr: REG_INTENSITY,  data: {4'h0, INTENSITY}},
		'{rsvd: 4'h0, addr: REG_SCAN_LIMIT, data: 8'h07},
		'{rsvd: 4'h0, addr: REG_SHUTDOWN,   data: 8'h01}
	};

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_LATCH
	} serial_state_t;

endpackage

// File: matrix_pkg.sv
//############################
// matrix package
// types and constants of the 8x8 game matrix, the player point
// and the row words sent toward the LED driver
//############################
package matrix_pkg;

	// rows and columns of the LED matrix
	localparam int MATRIX_SIZE = 8;

	typedef logic [2:0] row_idx_t;
	// bit c is column c
	typedef logic [7:0] row_bits_t;
	// row r sits at bits [8r+7:8r], row 0 is the bottom row
	typedef logic [63:0] frame_t;

	typedef struct packed {
		row_idx_t row;
		row_idx_t col;
	} point_pos_t;

	// single-cycle button pulses
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	typedef struct packed {
		row_idx_t  row;
		row_bits_t bits;
	} row_word_t;

	localparam frame_t BACKG_INIT = {8'hE0, 8'h00, 8'h00, 8'hE0, 8'h00, 8'hE0, 8'h00, 8'h00};
	localparam point_pos_t POINT_INIT = '{row: 3'd0, col: 3'd4};

endpackage
